//--- src.f
+incdir+src
src/lcd_pkg.sv
src/lcd_if.sv
src/tile_scanner.sv
src/lcd_decoder.sv
src/glyph_serializer.sv
src/lcd_bus_writer.sv
src/lcd_top.sv
sim/lcd_panel_model.sv
sim/lcd_top_tb.sv

//--- sim/lcd_top_tb.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcd_top_tb;
	import lcd_pkg::*;

	localparam int FRAME_BYTES = 2 * `LCD_PAGES * `LCD_HALF_COLS;
	localparam int WAIT_LIMIT = 20000; // cycles
	localparam int NUM_TESTS = 5;

	typedef struct packed {
		logic [1:0] row;
		logic [2:0] col;
		logic [7:0] code;
	} map_wr_t;

	typedef struct packed {
		logic [7:0] first_wr;
		logic [7:0] num_wr;
		logic [1:0] refreshes;
		logic pulses; // extra refresh pulses while busy
		logic rand_fill;
	} test_t;

	logic clk;
	logic arst_n;
	logic map_we;
	logic [1:0] map_row;
	logic [2:0] map_col;
	font_code_e map_font;
	logic refresh;
	logic busy;
	logic [1:0] lcd_cs;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_en;
	logic [7:0] lcd_data;

	font_code_e shadow [32]; // map contents as written
	int seed = 89427;
	int errors;
	int failed_tests;

	glyph_t glyph_rom [16] = '{`GLYPH_NONE, `GLYPH_SMILE, `GLYPH_ANGRY, `GLYPH_SLEEPY,
		`GLYPH_SHINE, `GLYPH_LOVE, `GLYPH_SAD, `GLYPH_LIKE, `GLYPH_WINK, `GLYPH_ARROW_UP,
		`GLYPH_ARROW_DOWN, `GLYPH_ARROW_LEFT, `GLYPH_ARROW_RIGHT, `GLYPH_DIGIT_1,
		`GLYPH_DIGIT_2, `GLYPH_DIGIT_3};

	map_wr_t wr_tab [13] = '{
		'{2'd0, 3'd0, FONT_SMILE}, '{2'd0, 3'd7, FONT_LOVE}, '{2'd1, 3'd3, FONT_ARROW_UP},
		'{2'd1, 3'd4, FONT_ARROW_DOWN}, '{2'd2, 3'd3, FONT_DIGIT_1}, '{2'd2, 3'd4, FONT_DIGIT_2},
		'{2'd3, 3'd0, FONT_DIGIT_3}, '{2'd3, 3'd7, FONT_WINK}, '{2'd2, 3'd0, FONT_ARROW_LEFT},
		'{2'd1, 3'd7, FONT_ARROW_RIGHT},
		'{2'd0, 3'd4, FONT_SAD}, '{2'd0, 3'd5, 8'hF0}, '{2'd0, 3'd6, FONT_ANGRY}};

	test_t test_tab [NUM_TESTS] = '{
		'{8'd0, 8'd0, 2'd1, 1'b0, 1'b0},
		'{8'd0, 8'd10, 2'd1, 1'b0, 1'b0},
		'{8'd10, 8'd3, 2'd1, 1'b0, 1'b0},
		'{8'd0, 8'd0, 2'd1, 1'b1, 1'b0},
		'{8'd0, 8'd0, 2'd2, 1'b0, 1'b1}};

	string test_name [NUM_TESTS] = '{"blank map", "glyph placement", "unknown code",
		"refresh while busy", "random map two frames"};

	lcd_top DUT (.clk(clk), .arst_n(arst_n), .map_we(map_we), .map_row(map_row),
		.map_col(map_col), .map_font(map_font), .refresh(refresh), .busy(busy),
		.lcd_cs(lcd_cs), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_en(lcd_en), .lcd_data(lcd_data));

	lcd_panel_model panel (.lcd_cs(lcd_cs), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_en(lcd_en),
		.lcd_data(lcd_data));

	always #20 clk = ~clk;

	task automatic check_byte(input lcd_byte_t exp, input lcd_byte_t got);
		if (exp !== got) begin
			$display("Fail t=%0t panel byte h%0d p%0d c%0d: expected %h got %h", $time,
				exp.half, exp.page, exp.column, exp, got);
			errors++;
		end
	endtask

	task automatic check_cmd(input string name, input lcd_cmd_e exp, input lcd_cmd_e got);
		if (exp !== got) begin
			$display("Fail t=%0t %s: expected %s got %s", $time, name, exp.name(), got.name());
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (exp != got) begin
			$display("Fail t=%0t %s: expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	// bit k of a byte is glyph row sub*8+k at the byte's column
	function automatic lcd_byte_t expected_byte(input int h, input int p, input int c);
		int tile;
		int sub;
		int gc;
		glyph_t g;
		lcd_byte_t b;
		tile = (p / 2) * 8 + h * 4 + c / 16;
		sub = p % 2;
		gc = c % 16;
		g = (8'(shadow[tile]) < 8'd16) ? glyph_rom[8'(shadow[tile])] : `GLYPH_NONE;
		for (int k = 0; k < 8; k++) begin
			b.data[k] = g[(sub * 8 + k) * 16 + gc];
		end
		b.half = h[0];
		b.page = p[2:0];
		b.column = c[5:0];
		b.last = (tile == 31) && (sub == 1) && (gc == 15);
		return b;
	endfunction

	task automatic write_map(input map_wr_t w);
		@(posedge clk);
		map_we <= 1'b1;
		map_row <= w.row;
		map_col <= w.col;
		map_font <= font_code_e'(w.code);
		shadow[{w.row, w.col}] = font_code_e'(w.code);
		@(posedge clk);
		map_we <= 1'b0;
	endtask

	task automatic wait_idle(input logic pulses);
		int cyc;
		cyc = 0;
		while (busy && cyc < WAIT_LIMIT) begin
			@(posedge clk);
			refresh <= pulses && (cyc < 2000) && (cyc % 300 == 5); // ignored by a busy DUT
			@(negedge clk);
			cyc++;
		end
		if (busy) begin
			$display("timeout: busy still high after %0d cycles at t=%0t", cyc, $time);
			errors++;
		end
	endtask

	task automatic run_frame(input logic pulses);
		int restarts;
		@(posedge clk);
		refresh <= 1'b1;
		@(posedge clk);
		refresh <= 1'b0;
		@(negedge clk);
		if (!busy) begin
			$display("busy did not rise after refresh at t=%0t", $time);
			errors++;
		end
		wait_idle(pulses);
		restarts = 0;
		repeat (64) begin
			@(negedge clk);
			if (busy) restarts++;
		end
		check_count("busy cycles after frame end", 0, restarts);
	endtask

	task automatic check_frame();
		lcd_byte_t got;
		check_count("data writes", FRAME_BYTES, panel.data_writes);
		check_count("bad strobes", 0, panel.bad_strobes);
		check_cmd("first frame command", SET_PAGE, panel.cmd_log[0]);
		for (int h = 0; h < 2; h++) begin
			for (int p = 0; p < `LCD_PAGES; p++) begin
				for (int c = 0; c < `LCD_HALF_COLS; c++) begin
					got.data = panel.fb[h][p][c];
					got.half = h[0];
					got.page = p[2:0];
					got.column = c[5:0];
					got.last = (panel.last_addr == h * 512 + p * 64 + c);
					check_byte(expected_byte(h, p, c), got);
				end
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int start);
		if (errors == start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d checks failed", num, name, errors - start);
		end
	endtask

	initial begin
		int r;
		int start;
		errors = 0;
		failed_tests = 0;
		clk = 1'b0;
		arst_n = 1'b0;
		map_we = 1'b0;
		map_row = '0;
		map_col = '0;
		map_font = FONT_NONE;
		refresh = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = FONT_NONE;
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);

		start = errors; // display-on to each half
		wait_idle(1'b0);
		check_count("commands after reset", 2, panel.cmd_count);
		check_cmd("reset command 0", DISPLAY_ON, panel.cmd_log[0]);
		check_count("reset command 0 half", 0, panel.half_log[0]);
		check_cmd("reset command 1", DISPLAY_ON, panel.cmd_log[1]);
		check_count("reset command 1 half", 1, panel.half_log[1]);
		report_test(1, "reset init", start);

		for (int t = 0; t < NUM_TESTS; t++) begin
			start = errors;
			for (int w = 0; w < test_tab[t].num_wr; w++) begin
				write_map(wr_tab[test_tab[t].first_wr + w]);
			end
			if (test_tab[t].rand_fill) begin
				for (int i = 0; i < 32; i++) begin
					r = $random(seed);
					write_map('{i[4:3], i[2:0], {4'h0, r[3:0]}});
				end
			end
			for (int f = 0; f < test_tab[t].refreshes; f++) begin
				panel.clear_log();
				run_frame(test_tab[t].pulses);
				check_frame();
			end
			report_test(t + 2, test_name[t], start);
		end

		$display("tests %0d, failed tests %0d, failed checks %0d", NUM_TESTS + 1,
			failed_tests, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim/lcd_panel_model.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcd_panel_model (
	input logic [1:0] lcd_cs,
	input logic lcd_rs,
	input logic lcd_rw,
	input logic lcd_en,
	input logic [7:0] lcd_data
);
	import lcd_pkg::*;

	localparam int LOG_DEPTH = 256;

	logic [7:0] fb [2][`LCD_PAGES][`LCD_HALF_COLS];
	logic [2:0] page_ptr [2];
	logic [5:0] col_ptr [2]; // auto-increments after each data byte
	lcd_cmd_e cmd_log [LOG_DEPTH];
	int half_log [LOG_DEPTH];
	int cmd_count;
	int data_writes;
	int bad_strobes; // cs not one-hot, read cycle or unknown command
	int last_addr; // {half, page, column} of the latest data byte
	logic half;

	task automatic clear_log();
		logic [9:0] a;
		for (int h = 0; h < 2; h++) begin
			for (int p = 0; p < `LCD_PAGES; p++) begin
				for (int c = 0; c < `LCD_HALF_COLS; c++) begin
					a = {h[0], p[2:0], c[5:0]};
					fb[h][p][c] = a[7:0] ^ {6'd0, a[9:8]} ^ 8'hA5;
				end
			end
		end
		cmd_log[0] = WRITE_DATA; // never logged, marks an empty log
		cmd_count = 0;
		data_writes = 0;
		bad_strobes = 0;
		last_addr = -1;
	endtask

	task automatic log_cmd(input lcd_cmd_e c);
		if (cmd_count < LOG_DEPTH) begin
			cmd_log[cmd_count] = c;
			half_log[cmd_count] = half;
		end
		cmd_count++;
	endtask

	initial begin
		page_ptr = '{default: '0};
		col_ptr = '{default: '0};
		clear_log();
	end

	always @(negedge lcd_en) begin
		half = lcd_cs[1];
		if (lcd_rw || !(lcd_cs == 2'b01 || lcd_cs == 2'b10)) begin
			bad_strobes++;
		end else if (lcd_rs) begin
			fb[half][page_ptr[half]][col_ptr[half]] = lcd_data;
			last_addr = {half, page_ptr[half], col_ptr[half]};
			col_ptr[half] = col_ptr[half] + 6'd1; // wraps like the panel
			data_writes++;
		end else if (lcd_data == `LCD_CMD_DISPLAY_ON) begin
			log_cmd(DISPLAY_ON);
		end else if ((lcd_data & 8'hF8) == `LCD_CMD_PAGE_BASE) begin
			page_ptr[half] = lcd_data[2:0];
			log_cmd(SET_PAGE);
		end else if ((lcd_data & 8'hC0) == `LCD_CMD_COLUMN_BASE) begin
			col_ptr[half] = lcd_data[5:0];
			log_cmd(SET_COLUMN);
		end else begin
			bad_strobes++;
		end
	end

endmodule

//--- src/lcd_top.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcd_top (
	input logic clk,
	input logic arst_n,
	input logic map_we,
	input logic [1:0] map_row,
	input logic [2:0] map_col,
	input lcd_pkg::font_code_e map_font,
	input logic refresh,
	output logic busy,
	output logic [1:0] lcd_cs,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_en,
	output logic [7:0] lcd_data
);

	tile_if #(.DEPTH(`LCD_TILE_CREDITS)) tile_bus ();
	glyph_if #(.DEPTH(1)) glyph_bus (); // serializer holds one glyph
	byte_if #(.DEPTH(`LCD_BYTE_CREDITS)) byte_bus ();

	logic writer_busy;
	logic frame_pend; // refresh taken, first byte not at the writer yet

	assign busy = writer_busy | frame_pend;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			frame_pend <= 1'b0;
		else if (writer_busy)
			frame_pend <= 1'b0;
		else if (refresh)
			frame_pend <= 1'b1;
	end

	tile_scanner u_scanner (.clk(clk), .arst_n(arst_n), .map_we(map_we), .map_row(map_row),
		.map_col(map_col), .map_font(map_font), .refresh(refresh), .frame_busy(busy),
		.tile(tile_bus.sender));

	lcd_decoder u_decoder (.clk(clk), .arst_n(arst_n), .tile(tile_bus.receiver),
		.glyph(glyph_bus.sender));

	glyph_serializer u_serializer (.clk(clk), .arst_n(arst_n), .glyph(glyph_bus.receiver),
		.bytes(byte_bus.sender));

	lcd_bus_writer u_writer (.clk(clk), .arst_n(arst_n), .bytes(byte_bus.receiver),
		.busy(writer_busy), .lcd_cs(lcd_cs), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw),
		.lcd_en(lcd_en), .lcd_data(lcd_data));

endmodule

//--- src/lcd_bus_writer.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcd_bus_writer (
	input logic clk,
	input logic arst_n,
	byte_if.receiver bytes,
	output logic busy,
	output logic [1:0] lcd_cs,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_en,
	output logic [7:0] lcd_data
);
	import lcd_pkg::*;

	localparam int AW = $clog2(`LCD_BYTE_CREDITS);
	localparam int EW = $clog2(`LCD_EN_CYCLES);
	localparam logic [EW-1:0] EN_LAST = EW'(`LCD_EN_CYCLES - 1);

	lcd_byte_t fifo_q [`LCD_BYTE_CREDITS];
	logic [AW-1:0] wp;
	logic [AW-1:0] rp;
	logic [AW:0] count;
	lcd_byte_t head;
	logic push;
	logic pop;
	logic start;

	bus_state_e state;
	lcd_cmd_e next_cmd;
	logic [EW-1:0] en_cnt;
	logic [1:0] init_cnt; // display-on commands sent
	logic end_q; // this transaction closes init or frame

	logic [2:0] page_q [2];
	logic [5:0] col_q [2]; // next column the panel will write
	logic [1:0] page_ok;
	logic [1:0] col_ok;

	assign head = fifo_q[rp];
	assign push = bytes.valid;
	assign start = (state == IDLE) && ((init_cnt != 2'd2) || (count != '0));
	assign pop = start && (next_cmd == WRITE_DATA);
	assign bytes.credit_return = pop;

	assign lcd_en = (state == STROBE);
	assign lcd_rw = 1'b0; // write only

	always_comb begin
		next_cmd = WRITE_DATA;
		if (init_cnt != 2'd2)
			next_cmd = DISPLAY_ON;
		else if (!page_ok[head.half] || (page_q[head.half] != head.page))
			next_cmd = SET_PAGE;
		else if (!col_ok[head.half] || (col_q[head.half] != head.column))
			next_cmd = SET_COLUMN;
	end

	always_ff @(posedge clk) begin
		if (push) fifo_q[wp] <= bytes.payload;
		if (start) begin
			case (next_cmd)
				DISPLAY_ON: lcd_data <= `LCD_CMD_DISPLAY_ON;
				SET_PAGE: begin
					lcd_data <= `LCD_CMD_PAGE_BASE | {5'd0, head.page};
					page_q[head.half] <= head.page;
				end
				SET_COLUMN: begin
					lcd_data <= `LCD_CMD_COLUMN_BASE | {2'd0, head.column};
					col_q[head.half] <= head.column;
				end
				default: begin
					lcd_data <= head.data;
					col_q[head.half] <= head.column + 6'd1; // panel auto-increment
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wp <= '0;
			rp <= '0;
			count <= '0;
		end else begin
			if (push) wp <= wp + 1'b1;
			if (pop) rp <= rp + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			en_cnt <= '0;
			init_cnt <= 2'd0;
			end_q <= 1'b0;
			lcd_cs <= 2'b00;
			lcd_rs <= 1'b0;
			page_ok <= 2'b00;
			col_ok <= 2'b00;
			busy <= 1'b1;
		end else begin
			if ((state == HOLD) && end_q)
				busy <= 1'b0;
			else if (push)
				busy <= 1'b1;
			case (state)
				IDLE: if (start) begin
					state <= SETUP;
					lcd_cs <= {head.half, ~head.half};
					lcd_rs <= (next_cmd == WRITE_DATA);
					end_q <= 1'b0;
					case (next_cmd)
						DISPLAY_ON: begin
							lcd_cs <= init_cnt[0] ? 2'b10 : 2'b01;
							init_cnt <= init_cnt + 2'd1;
							end_q <= init_cnt[0];
						end
						SET_PAGE: page_ok[head.half] <= 1'b1;
						SET_COLUMN: col_ok[head.half] <= 1'b1;
						default: end_q <= head.last;
					endcase
				end
				SETUP: begin
					state <= STROBE;
					en_cnt <= '0;
				end
				STROBE: begin
					if (en_cnt == EN_LAST) state <= HOLD;
					en_cnt <= en_cnt + 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- src/glyph_serializer.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module glyph_serializer (
	input logic clk,
	input logic arst_n,
	glyph_if.receiver glyph,
	byte_if.sender bytes
);
	import lcd_pkg::*;

	localparam logic [1:0] LAST_ROW = 2'(`LCD_TILE_ROWS - 1);
	localparam logic [2:0] LAST_COL = 3'(`LCD_TILE_COLS - 1);

	glyph_t glyph_q;
	logic [1:0] row_q;
	logic [2:0] col_q;
	logic full;
	logic [4:0] idx; // {sub-page, column in glyph}
	logic send;
	logic last_byte;
	logic [7:0] data;

	assign send = full && (bytes.credits != '0);
	assign last_byte = (idx == 5'd31);

	// bit k is pixel row sub*8+k of the current column
	always_comb begin
		for (int k = 0; k < 8; k++) begin
			data[k] = glyph_q[{idx[4], 3'(k), idx[3:0]}];
		end
	end

	always_ff @(posedge clk) begin
		if (glyph.valid) begin
			glyph_q <= glyph.payload.glyph;
			row_q <= glyph.payload.tile_row;
			col_q <= glyph.payload.tile_col;
		end
		if (send) begin
			bytes.payload <= '{data: data, half: col_q[2], page: {row_q, idx[4]},
				column: {col_q[1:0], idx[3:0]},
				last: last_byte && (row_q == LAST_ROW) && (col_q == LAST_COL)};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
			idx <= '0;
			bytes.valid <= 1'b0;
			bytes.credits <= bytes.FULL;
			glyph.credit_return <= 1'b0;
		end else begin
			bytes.valid <= send;
			glyph.credit_return <= send && last_byte; // glyph fully sent
			if (glyph.valid) begin
				full <= 1'b1;
				idx <= '0;
			end else if (send) begin
				idx <= idx + 5'd1;
				if (last_byte) full <= 1'b0;
			end
			case ({send, bytes.credit_return})
				2'b10: bytes.credits <= bytes.credits - 1'b1;
				2'b01: bytes.credits <= bytes.credits + 1'b1;
				default: bytes.credits <= bytes.credits;
			endcase
		end
	end

endmodule

//--- src/lcd_decoder.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcd_decoder (
	input logic clk,
	input logic arst_n,
	tile_if.receiver tile,
	glyph_if.sender glyph
);
	import lcd_pkg::*;

	glyph_t look;
	glyph_req_t res_q [2];
	logic wp;
	logic rp;
	logic [1:0] count;
	logic push;
	logic pop;

	always_comb begin
		case (tile.payload.font)
			FONT_NONE: look = `GLYPH_NONE;
			FONT_SMILE: look = `GLYPH_SMILE;
			FONT_ANGRY: look = `GLYPH_ANGRY;
			FONT_SLEEPY: look = `GLYPH_SLEEPY;
			FONT_SHINE: look = `GLYPH_SHINE;
			FONT_LOVE: look = `GLYPH_LOVE;
			FONT_SAD: look = `GLYPH_SAD;
			FONT_LIKE: look = `GLYPH_LIKE;
			FONT_WINK: look = `GLYPH_WINK;
			FONT_ARROW_UP: look = `GLYPH_ARROW_UP;
			FONT_ARROW_DOWN: look = `GLYPH_ARROW_DOWN;
			FONT_ARROW_LEFT: look = `GLYPH_ARROW_LEFT;
			FONT_ARROW_RIGHT: look = `GLYPH_ARROW_RIGHT;
			FONT_DIGIT_1: look = `GLYPH_DIGIT_1;
			FONT_DIGIT_2: look = `GLYPH_DIGIT_2;
			FONT_DIGIT_3: look = `GLYPH_DIGIT_3;
			default: look = `GLYPH_NONE; // unknown code shows blank
		endcase
	end

	assign push = tile.valid;
	assign pop = (count != 2'd0) && (glyph.credits != '0);

	assign glyph.valid = pop;
	assign glyph.payload = res_q[rp];
	assign tile.credit_return = pop; // slot freed

	always_ff @(posedge clk) begin
		if (push) begin
			res_q[wp] <= '{glyph: look, tile_row: tile.payload.tile_row,
				tile_col: tile.payload.tile_col};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wp <= 1'b0;
			rp <= 1'b0;
			count <= 2'd0;
			glyph.credits <= glyph.FULL;
		end else begin
			if (push) wp <= ~wp;
			if (pop) rp <= ~rp;
			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
			case ({pop, glyph.credit_return})
				2'b10: glyph.credits <= glyph.credits - 1'b1;
				2'b01: glyph.credits <= glyph.credits + 1'b1;
				default: glyph.credits <= glyph.credits;
			endcase
		end
	end

endmodule

//--- src/tile_scanner.sv
`timescale 1ns/10ps
`include "lcd_consts.svh"

module tile_scanner (
	input logic clk,
	input logic arst_n,
	input logic map_we,
	input logic [1:0] map_row,
	input logic [2:0] map_col,
	input lcd_pkg::font_code_e map_font,
	input logic refresh,
	input logic frame_busy,
	tile_if.sender tile
);
	import lcd_pkg::*;

	localparam int TILES = `LCD_TILE_ROWS * `LCD_TILE_COLS;
	localparam logic [4:0] LAST_TILE = 5'(TILES - 1);

	font_code_e map_q [TILES];
	logic active;
	logic [4:0] idx; // {row, col}, row-major walk
	logic send;

	assign send = active && (tile.credits != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < TILES; i++) begin
				map_q[i] <= FONT_NONE;
			end
		end else if (map_we) begin
			map_q[{map_row, map_col}] <= map_font;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			idx <= '0;
		end else if (send) begin
			idx <= idx + 5'd1;
			active <= (idx != LAST_TILE); // stop after the last tile
		end else if (refresh && !frame_busy && !active) begin
			active <= 1'b1;
			idx <= '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tile.valid <= 1'b0;
			tile.credits <= tile.FULL;
		end else begin
			tile.valid <= send;
			case ({send, tile.credit_return})
				2'b10: tile.credits <= tile.credits - 1'b1;
				2'b01: tile.credits <= tile.credits + 1'b1;
				default: tile.credits <= tile.credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			tile.payload <= '{font: map_q[idx], tile_row: idx[4:3], tile_col: idx[2:0]};
		end
	end

endmodule

//--- src/lcd_if.sv
`timescale 1ns/10ps

interface tile_if #(
	parameter int DEPTH = 2
);
	import lcd_pkg::*;

	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] FULL = CW'(DEPTH);

	logic valid;
	tile_req_t payload;
	logic credit_return;
	logic [CW-1:0] credits; // kept by the sender

	modport sender (output valid, payload, credits, input credit_return);
	modport receiver (input valid, payload, output credit_return);
endinterface

interface glyph_if #(
	parameter int DEPTH = 1
);
	import lcd_pkg::*;

	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] FULL = CW'(DEPTH);

	logic valid;
	glyph_req_t payload;
	logic credit_return;
	logic [CW-1:0] credits;

	modport sender (output valid, payload, credits, input credit_return);
	modport receiver (input valid, payload, output credit_return);
endinterface

interface byte_if #(
	parameter int DEPTH = 4
);
	import lcd_pkg::*;

	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] FULL = CW'(DEPTH);

	logic valid;
	lcd_byte_t payload;
	logic credit_return;
	logic [CW-1:0] credits;

	modport sender (output valid, payload, credits, input credit_return);
	modport receiver (input valid, payload, output credit_return);
endinterface

//--- src/lcd_pkg.sv
package lcd_pkg;

	typedef enum logic [7:0] {
		FONT_NONE = 8'd0,
		FONT_SMILE,
		FONT_ANGRY,
		FONT_SLEEPY,
		FONT_SHINE,
		FONT_LOVE,
		FONT_SAD,
		FONT_LIKE,
		FONT_WINK,
		FONT_ARROW_UP,
		FONT_ARROW_DOWN,
		FONT_ARROW_LEFT,
		FONT_ARROW_RIGHT,
		FONT_DIGIT_1,
		FONT_DIGIT_2,
		FONT_DIGIT_3
	} font_code_e;

	typedef logic [255:0] glyph_t; // bit row*16+col

	typedef struct packed {
		font_code_e font;
		logic [1:0] tile_row;
		logic [2:0] tile_col;
	} tile_req_t;

	typedef struct packed {
		glyph_t glyph;
		logic [1:0] tile_row;
		logic [2:0] tile_col;
	} glyph_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic half;
		logic [2:0] page;
		logic [5:0] column;
		logic last; // final byte of the frame
	} lcd_byte_t;

	typedef enum logic [1:0] {DISPLAY_ON, SET_PAGE, SET_COLUMN, WRITE_DATA} lcd_cmd_e;

	typedef enum logic [1:0] {IDLE, SETUP, STROBE, HOLD} bus_state_e;

endpackage

//--- src/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// screen geometry
`define LCD_TILE_ROWS 4
`define LCD_TILE_COLS 8
`define LCD_HALF_COLS 64
`define LCD_PAGES 8

// receiver depths of the credit streams
`define LCD_TILE_CREDITS 2
`define LCD_BYTE_CREDITS 4

`define LCD_EN_CYCLES 4 // enable high time in clocks

// KS0108 commands, address goes into the low bits of page and column
`define LCD_CMD_DISPLAY_ON 8'h3F
`define LCD_CMD_PAGE_BASE 8'hB8
`define LCD_CMD_COLUMN_BASE 8'h40

// glyph bit row*16+col, so the first hex group is row 15
`define GLYPH_NONE 256'h0
`define GLYPH_SMILE \
	256'h07E018182004400247E288119009800180014812481240022004181807E00000
`define GLYPH_ANGRY \
	256'h07E0181820044002481287E18001800180014812481251AA2004181807E00000
`define GLYPH_SLEEPY \
	256'h07E01818200440024002818180018001800150BA400240022004181807E00000
`define GLYPH_SHINE \
	256'h07E018182004400247E288119FF980018001481251AA48122004181807E00000
`define GLYPH_LOVE \
	256'h07E018182004400247E28811800180018811463257EA46322004181807E00000
`define GLYPH_SAD \
	256'h07E018182004400250088811840180018001481248124002200418180FE00000
`define GLYPH_LIKE \
	256'h07E018182004400243C2842187E180018001481248124002200418180FE00000
`define GLYPH_WINK \
	256'h07E018182004400247E28811900980018001507240124002200418180FE00000

// arrows and digits
`define GLYPH_ARROW_UP \
	256'h00000180018001800180018001800180018001801FF80FF007E003C001800000
`define GLYPH_ARROW_DOWN \
	256'h0000018003C007E00FF01FF80180018001800180018001800180018001800000
`define GLYPH_ARROW_LEFT \
	256'h00000000000000000020003000387FFC7FFC0038003000200000000000000000
`define GLYPH_ARROW_RIGHT \
	256'h00000000000000000400_0C001C003FFE3FFE1C000C0004000000000000000000
`define GLYPH_DIGIT_1 \
	256'h0000000007E001800180018001800180018001800180_01A001C0018000000000
`define GLYPH_DIGIT_2 \
	256'h000000000FF000300030006000C0018003000600_0C000C000C3007E000000000
`define GLYPH_DIGIT_3 \
	256'h00000000000007E00C300C000C00060003C00600_0C000C000C3007E000000000

`endif
